// File: hw/cache_pkg.sv
// Shared cache types, geometry constants, data cache state encoding and hit counter address.
package cache_pkg;

	// Data and address word.
	typedef logic [31:0] word_t;

	// Data cache address fields.
	typedef logic [25:0] dtag_t;   // Address bits 31 to 6.
	typedef logic [2:0]  didx_t;   // Address bits 5 to 3.

	// Instruction cache address fields.
	typedef logic [25:0] itag_t;   // Address bits 31 to 6.
	typedef logic [3:0]  iidx_t;   // Address bits 5 to 2.

	// Geometry.
	localparam int DSETS = 8;      // Sets per data cache way.
	localparam int ISETS = 16;     // Instruction cache entries.

	// Hit counter lands here after the halt flush.
	localparam word_t HIT_CNT_ADDR = 32'h0000_3100;

	// Data cache controller states.
	typedef enum logic [3:0]
	{
		IDLE,
		WB1,
		WB2,
		LD1,
		LD2,
		CLEAN,
		FLUSH1,
		FLUSH2,
		HLT_CNT,
		HALTED
	} dstate_t;

	// IDLE      serves hits, starts misses and halt.
	// WB1, WB2  write the dirty victim block back.
	// LD1, LD2  fetch the missing block.
	// CLEAN     walks the sets looking for dirty ways.
	// FLUSH1/2  write one dirty way to its own block address.
	// HLT_CNT   stores the hit counter.
	// HALTED    flushed_o stays high until reset.

endpackage

// File: hw/dcache.sv
// Data cache: two-way set associative write-back cache with LRU, halt flush and hit counter.
`timescale 1ns/100ps

module dcache import cache_pkg::*;
(
	input  logic  CLK,
	input  logic  nRST,
	input  logic  dmemren_i,
	input  logic  dmemwen_i,
	input  word_t dmemaddr_i,
	input  word_t dmemstore_i,
	input  logic  halt_i,
	input  word_t dload_i,
	input  logic  dwait_i,
	output logic  dhit_o,
	output word_t dmemload_o,
	output logic  flushed_o,
	output logic  dren_o,
	output logic  dwen_o,
	output word_t daddr_o,
	output word_t dstore_o
);
	dtag_t atag;
	didx_t aidx;
	logic aword;
	logic req;
	logic access;
	logic [1:0] hit_way;
	logic hit;
	logic hway;
	logic victim;
	logic victim_dirty;
	didx_t fset;
	logic fdirty;
	logic fway;

	// Frame storage, indexed [way][set].
	logic  valid [2][DSETS];
	logic  dirty [2][DSETS];
	dtag_t tags  [2][DSETS];
	word_t data0 [2][DSETS];
	word_t data1 [2][DSETS];
	logic  lru   [DSETS];   // Names the victim way.

	dstate_t state, next_state;
	logic [3:0] flush_idx;
	logic signed [31:0] hit_cnt;
	logic first_q;   // Next lookup of this access is its first.

	assign atag  = dmemaddr_i[31:6];
	assign aidx  = dmemaddr_i[5:3];
	assign aword = dmemaddr_i[2];
	assign req   = dmemren_i || dmemwen_i;

	assign hit_way[0] = valid[0][aidx] && (tags[0][aidx] == atag);
	assign hit_way[1] = valid[1][aidx] && (tags[1][aidx] == atag);
	assign hit  = |hit_way;
	assign hway = hit_way[1];

	assign victim       = lru[aidx];
	assign victim_dirty = valid[victim][aidx] && dirty[victim][aidx];

	// Flush walk picks way 0 first when both are dirty.
	assign fset   = flush_idx[2:0];
	assign fdirty = dirty[0][fset] || dirty[1][fset];
	assign fway   = !dirty[0][fset];

	assign access     = (state == IDLE) && req && !halt_i;
	assign dhit_o     = access && hit;
	assign dmemload_o = aword ? data1[hway][aidx] : data0[hway][aidx];
	assign flushed_o  = (state == HALTED);

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
			begin
				if (halt_i)
					next_state = CLEAN;
				else if (req && !hit)
					next_state = victim_dirty ? WB1 : LD1;
			end
			WB1:     if (!dwait_i) next_state = WB2;
			WB2:     if (!dwait_i) next_state = LD1;
			LD1:     if (!dwait_i) next_state = LD2;
			LD2:     if (!dwait_i) next_state = IDLE;
			CLEAN:
			begin
				if (flush_idx == 4'(DSETS))
					next_state = HLT_CNT;
				else if (fdirty)
					next_state = FLUSH1;
			end
			FLUSH1:  if (!dwait_i) next_state = FLUSH2;
			FLUSH2:  if (!dwait_i) next_state = CLEAN;
			HLT_CNT: if (!dwait_i) next_state = HALTED;
			HALTED:  next_state = HALTED;
			default: next_state = IDLE;
		endcase
	end

	// RAM side requests.
	always_comb
	begin
		dren_o   = 1'b0;
		dwen_o   = 1'b0;
		daddr_o  = '0;
		dstore_o = '0;
		case (state)
			WB1:
			begin
				dwen_o   = 1'b1;
				daddr_o  = {tags[victim][aidx], aidx, 3'b000};   // Victim's own block.
				dstore_o = data0[victim][aidx];
			end
			WB2:
			begin
				dwen_o   = 1'b1;
				daddr_o  = {tags[victim][aidx], aidx, 3'b100};
				dstore_o = data1[victim][aidx];
			end
			LD1:
			begin
				dren_o  = 1'b1;
				daddr_o = {atag, aidx, 3'b000};
			end
			LD2:
			begin
				dren_o  = 1'b1;
				daddr_o = {atag, aidx, 3'b100};
			end
			FLUSH1:
			begin
				dwen_o   = 1'b1;
				daddr_o  = {tags[fway][fset], fset, 3'b000};
				dstore_o = data0[fway][fset];
			end
			FLUSH2:
			begin
				dwen_o   = 1'b1;
				daddr_o  = {tags[fway][fset], fset, 3'b100};
				dstore_o = data1[fway][fset];
			end
			HLT_CNT:
			begin
				dwen_o   = 1'b1;
				daddr_o  = HIT_CNT_ADDR;
				dstore_o = word_t'(hit_cnt);
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			state     <= IDLE;
			flush_idx <= '0;
			hit_cnt   <= '0;
			first_q   <= 1'b1;
			for (int s = 0; s < DSETS; s++)
			begin
				valid[0][s] <= 1'b0;
				valid[1][s] <= 1'b0;
				dirty[0][s] <= 1'b0;
				dirty[1][s] <= 1'b0;
				lru[s]      <= 1'b0;
			end
		end
		else
		begin
			state <= next_state;
			case (state)
				IDLE:
				begin
					if (access && hit)
					begin
						lru[aidx] <= !hway;
						if (dmemwen_i)
							dirty[hway][aidx] <= 1'b1;
						if (first_q)
							hit_cnt <= hit_cnt + 32'sd1;
						first_q <= 1'b1;
					end
					else if (access)
					begin
						if (first_q)
							hit_cnt <= hit_cnt - 32'sd1;
						first_q <= 1'b0;   // Refill lookup does not count.
					end
				end
				LD2:
				begin
					if (!dwait_i)
					begin
						valid[victim][aidx] <= 1'b1;
						dirty[victim][aidx] <= 1'b0;
						lru[aidx]           <= !victim;
					end
				end
				CLEAN:
				begin
					if (flush_idx != 4'(DSETS) && !fdirty)
						flush_idx <= flush_idx + 4'd1;
				end
				FLUSH2: if (!dwait_i) dirty[fway][fset] <= 1'b0;
				default: ;
			endcase
		end
	end

	// Tags and data words.
	always_ff @(posedge CLK)
	begin
		if (access && hit && dmemwen_i)
		begin
			if (aword)
				data1[hway][aidx] <= dmemstore_i;
			else
				data0[hway][aidx] <= dmemstore_i;
		end
		if (state == LD1 && !dwait_i)
			data0[victim][aidx] <= dload_i;
		if (state == LD2 && !dwait_i)
		begin
			data1[victim][aidx] <= dload_i;
			tags[victim][aidx]  <= atag;
		end
	end

endmodule

// File: hw/icache.sv
// Instruction cache: direct mapped, read only, sixteen one-word entries.
`timescale 1ns/100ps

module icache import cache_pkg::*;
(
	input  logic  CLK,
	input  logic  nRST,
	input  logic  imemren_i,
	input  word_t imemaddr_i,
	input  word_t iload_i,
	input  logic  iwait_i,
	output logic  ihit_o,
	output word_t imemload_o,
	output logic  iren_o,
	output word_t iaddr_o
);
	typedef enum logic
	{
		I_IDLE,
		I_FETCH
	} istate_t;

	itag_t atag;
	iidx_t aidx;
	logic hit;

	logic  valid [ISETS];
	itag_t tags  [ISETS];
	word_t data  [ISETS];

	istate_t state;

	assign atag = imemaddr_i[31:6];
	assign aidx = imemaddr_i[5:2];
	assign hit  = valid[aidx] && (tags[aidx] == atag);

	assign ihit_o     = (state == I_IDLE) && imemren_i && hit;
	assign imemload_o = data[aidx];

	// Word aligned fetch while a miss is outstanding.
	assign iren_o  = (state == I_FETCH);
	assign iaddr_o = (state == I_FETCH) ? {imemaddr_i[31:2], 2'b00} : '0;

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			state <= I_IDLE;
			for (int e = 0; e < ISETS; e++)
				valid[e] <= 1'b0;
		end
		else
		begin
			case (state)
				I_IDLE:  if (imemren_i && !hit) state <= I_FETCH;
				I_FETCH:
				begin
					if (!iwait_i)
					begin
						valid[aidx] <= 1'b1;
						state       <= I_IDLE;   // Hits on the next cycle.
					end
				end
				default: state <= I_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (state == I_FETCH && !iwait_i)
		begin
			tags[aidx] <= atag;
			data[aidx] <= iload_i;
		end
	end

endmodule

// File: hw/memory_control.sv
// Memory controller: fixed priority arbiter merging data and instruction cache requests onto RAM.
`timescale 1ns/100ps

module memory_control import cache_pkg::*;
(
	input  logic  dren_i,
	input  logic  dwen_i,
	input  word_t daddr_i,
	input  word_t dstore_i,
	input  logic  iren_i,
	input  word_t iaddr_i,
	input  word_t ram_load_i,
	input  logic  ram_wait_i,
	output logic  ram_ren_o,
	output logic  ram_wen_o,
	output word_t ram_addr_o,
	output word_t ram_store_o,
	output word_t dload_o,
	output logic  dwait_o,
	output word_t iload_o,
	output logic  iwait_o
);
	logic dsel;

	// Data cache wins whenever it asks.
	assign dsel = dren_i || dwen_i;

	always_comb
	begin
		if (dsel)
		begin
			ram_ren_o   = dren_i;
			ram_wen_o   = dwen_i;
			ram_addr_o  = daddr_i;
			ram_store_o = dstore_i;
			dwait_o     = ram_wait_i;
			iwait_o     = 1'b1;   // Instruction side held off.
		end
		else
		begin
			ram_ren_o   = iren_i;
			ram_wen_o   = 1'b0;
			ram_addr_o  = iaddr_i;
			ram_store_o = '0;
			dwait_o     = 1'b1;
			iwait_o     = ram_wait_i;
		end
	end

	// Load data goes to both sides, only the served one sees wait low.
	assign dload_o = ram_load_i;
	assign iload_o = ram_load_i;

endmodule

// File: hw/cache_subsystem.sv
// Top level of the cache subsystem: data cache, instruction cache and memory controller.
`timescale 1ns/100ps

module cache_subsystem import cache_pkg::*;
(
	input  logic  CLK,
	input  logic  nRST,
	// Data side.
	input  logic  dmemren_i,
	input  logic  dmemwen_i,
	input  word_t dmemaddr_i,
	input  word_t dmemstore_i,
	input  logic  halt_i,
	output logic  dhit_o,
	output word_t dmemload_o,
	output logic  flushed_o,
	// Instruction side.
	input  logic  imemren_i,
	input  word_t imemaddr_i,
	output logic  ihit_o,
	output word_t imemload_o,
	// RAM port.
	output logic  ram_ren_o,
	output logic  ram_wen_o,
	output word_t ram_addr_o,
	output word_t ram_store_o,
	input  word_t ram_load_i,
	input  logic  ram_wait_i
);
	logic  dren;
	logic  dwen;
	word_t daddr;
	word_t dstore;
	word_t dload;
	logic  dwait;
	logic  iren;
	word_t iaddr;
	word_t iload;
	logic  iwait;

	dcache dcache_i
	(
		.CLK(CLK), .nRST(nRST),
		.dmemren_i(dmemren_i), .dmemwen_i(dmemwen_i),
		.dmemaddr_i(dmemaddr_i), .dmemstore_i(dmemstore_i), .halt_i(halt_i),
		.dload_i(dload), .dwait_i(dwait),
		.dhit_o(dhit_o), .dmemload_o(dmemload_o), .flushed_o(flushed_o),
		.dren_o(dren), .dwen_o(dwen), .daddr_o(daddr), .dstore_o(dstore)
	);

	icache icache_i
	(
		.CLK(CLK), .nRST(nRST),
		.imemren_i(imemren_i), .imemaddr_i(imemaddr_i),
		.iload_i(iload), .iwait_i(iwait),
		.ihit_o(ihit_o), .imemload_o(imemload_o),
		.iren_o(iren), .iaddr_o(iaddr)
	);

	memory_control memory_control_i
	(
		.dren_i(dren), .dwen_i(dwen), .daddr_i(daddr), .dstore_i(dstore),
		.iren_i(iren), .iaddr_i(iaddr),
		.ram_load_i(ram_load_i), .ram_wait_i(ram_wait_i),
		.ram_ren_o(ram_ren_o), .ram_wen_o(ram_wen_o),
		.ram_addr_o(ram_addr_o), .ram_store_o(ram_store_o),
		.dload_o(dload), .dwait_o(dwait), .iload_o(iload), .iwait_o(iwait)
	);

endmodule

// File: test/cache_subsystem_props.sv
// Bound data cache assertions: request exclusivity, request hold under wait, sticky flushed level.
`timescale 1ns/100ps

module cache_subsystem_props import cache_pkg::*;
(
	input logic  CLK,
	input logic  nRST,
	input logic  dren_i,
	input logic  dwen_i,
	input word_t daddr_i,
	input logic  dwait_i,
	input logic  flushed_i
);
	assert property (@(posedge CLK) disable iff (!nRST) !(dren_i && dwen_i))
		else $error("RAM read and write requests are high together.");

	// A stalled request keeps its kind and address.
	assert property (@(posedge CLK) disable iff (!nRST)
		(dren_i || dwen_i) && dwait_i |=> $stable(daddr_i) && $stable(dren_i) && $stable(dwen_i))
		else $error("RAM request changed while wait was high.");

	assert property (@(posedge CLK) disable iff (!nRST) flushed_i |=> flushed_i)
		else $error("flushed_o fell after the flush completed.");   // Only reset clears it.

endmodule

bind dcache cache_subsystem_props props_i
(
	.CLK(CLK),
	.nRST(nRST),
	.dren_i(dren_o),
	.dwen_i(dwen_o),
	.daddr_i(daddr_o),
	.dwait_i(dwait_i),
	.flushed_i(flushed_o)
);

// File: test/cache_subsystem_tb.sv
// Testbench with clock and reset, RAM model, LRU reference model, stimulus and output checks.
`timescale 1ns/100ps

module cache_subsystem_tb import cache_pkg::*; ();
	localparam int NRAND     = 240;
	localparam int NACC      = NRAND + 16;
	localparam int MISS_CYC  = 20;   // Two writebacks and two fills, up to four cycles each.
	localparam int FLUSH_CYC = 2 * DSETS * 2 * 4 + DSETS + 16;
	localparam int LIMIT     = NACC * MISS_CYC + FLUSH_CYC;

	logic  CLK = 1'b0;
	logic  nRST;
	logic  dmemren_i;
	logic  dmemwen_i;
	word_t dmemaddr_i;
	word_t dmemstore_i;
	logic  halt_i;
	logic  dhit_o;
	word_t dmemload_o;
	logic  flushed_o;
	logic  imemren_i;
	word_t imemaddr_i;
	logic  ihit_o;
	word_t imemload_o;
	logic  ram_ren_o;
	logic  ram_wen_o;
	word_t ram_addr_o;
	word_t ram_store_o;
	word_t ram_load_i;
	logic  ram_wait_i;

	word_t ram  [word_t];   // Sparse RAM contents.
	word_t gold [word_t];   // Last value stored to each data word.
	logic  model_valid [2][DSETS];
	logic  model_dirty [2][DSETS];
	dtag_t model_tag   [2][DSETS];
	logic  model_lru   [DSETS];
	int    model_cnt = 0;
	word_t wb_addr [$];     // Writebacks predicted by the model, in order.
	word_t wb_data [$];
	word_t exp_dload;
	word_t exp_iload;
	bit    rnd_wr   [NRAND];
	word_t rnd_addr [NRAND];
	word_t rnd_data [NRAND];
	int    cycles = 0;
	int    remain = -1;
	bit    flushing = 1'b0;
	int    err_data = 0;
	int    err_inst = 0;
	int    err_ram = 0;
	int    err_seq = 0;

	cache_subsystem cache_subsystem_i (.*);

	always #4 CLK = ~CLK;

	function automatic word_t fill_pattern(input word_t addr);
		return (addr * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;   // Unwritten RAM words.
	endfunction

	function automatic word_t golden_word(input word_t addr);
		return gold.exists(addr) ? gold[addr] : fill_pattern(addr);
	endfunction

	function automatic word_t ram_word(input word_t addr);
		return ram.exists(addr) ? ram[addr] : fill_pattern(addr);
	endfunction

	// Two-way LRU model. Returns the expected load and whether the first lookup hits.
	function automatic word_t predict_access(input bit wr, input word_t addr, input word_t wdata,
		output bit first_hit);
		dtag_t t;
		didx_t s;
		int w;
		word_t base;
		t = addr[31:6];
		s = addr[5:3];
		first_hit = 1'b0;
		w = 0;
		for (int k = 0; k < 2; k++)
		begin
			if (model_valid[k][s] && model_tag[k][s] == t)
			begin
				first_hit = 1'b1;
				w = k;
			end
		end
		if (first_hit)
			model_cnt++;
		else
		begin
			model_cnt--;
			w = int'(model_lru[s]);
			if (model_valid[w][s] && model_dirty[w][s])
			begin
				base = {model_tag[w][s], s, 3'b000};   // Victim goes to its own block.
				wb_addr.push_back(base);
				wb_data.push_back(golden_word(base));
				wb_addr.push_back(base + 32'd4);
				wb_data.push_back(golden_word(base + 32'd4));
			end
			model_valid[w][s] = 1'b1;
			model_dirty[w][s] = 1'b0;
			model_tag[w][s]   = t;
		end
		model_lru[s] = (w == 0);
		if (wr)
		begin
			gold[{addr[31:2], 2'b00}] = wdata;
			model_dirty[w][s] = 1'b1;
		end
		return golden_word({addr[31:2], 2'b00});
	endfunction

	task automatic check_writeback(input word_t addr, input word_t data);
		word_t ea;
		word_t ed;
		assert (wb_addr.size() != 0)
		else
		begin
			err_ram++;
			$display("RAM write to %h at %0t was not expected by the reference model", addr, $time);
		end
		if (wb_addr.size() != 0)
		begin
			ea = wb_addr.pop_front();
			ed = wb_data.pop_front();
			assert (addr == ea)
			else
			begin
				err_ram++;
				$display("Fail t=%0t ram_addr_o dut=%h exp=%h", $time, addr, ea);
			end
			assert (data == ed)
			else
			begin
				err_ram++;
				$display("Fail t=%0t ram_store_o dut=%h exp=%h", $time, data, ed);
			end
		end
	endtask

	// Starts at a falling edge and returns at one with the request dropped.
	task automatic data_access(input bit wr, input word_t addr, input word_t wdata,
		output time done);
		bit first_hit;
		int waited;
		exp_dload   = predict_access(wr, addr, wdata, first_hit);
		dmemren_i   = !wr;
		dmemwen_i   = wr;
		dmemaddr_i  = addr;
		dmemstore_i = wdata;
		waited = 0;
		@(posedge CLK);
		while (!dhit_o)
		begin
			waited++;
			@(posedge CLK);
		end
		done = $time;
		assert ((waited == 0) == first_hit)
		else
		begin
			err_data++;
			$display("Fail t=%0t dhit_o first lookup dut=%0b exp=%0b", $time, waited == 0, first_hit);
		end
		@(negedge CLK);
		dmemren_i = 1'b0;
		dmemwen_i = 1'b0;
	endtask

	task automatic fetch_instr(input word_t addr, input bit hit_exp, output time done);
		int waited;
		exp_iload  = fill_pattern(addr);   // Fetch region is never written.
		imemren_i  = 1'b1;
		imemaddr_i = addr;
		waited = 0;
		@(posedge CLK);
		while (!ihit_o)
		begin
			waited++;
			@(posedge CLK);
		end
		done = $time;
		assert ((waited == 0) == hit_exp)
		else
		begin
			err_inst++;
			$display("Fail t=%0t ihit_o first lookup dut=%0b exp=%0b", $time, waited == 0, hit_exp);
		end
		@(negedge CLK);
		imemren_i = 1'b0;
	endtask

	// RAM answers each request after 0 to 3 wait cycles.
	always @(negedge CLK)
	begin
		if (ram_ren_o || ram_wen_o)
		begin
			if (remain < 0)
				remain = int'($urandom_range(3, 0));
			ram_wait_i = (remain != 0);
			if (remain == 0)
			begin
				ram_load_i = ram_word(ram_addr_o);
				if (ram_wen_o && !flushing)
					check_writeback(ram_addr_o, ram_store_o);
				if (ram_wen_o)
					ram[ram_addr_o] = ram_store_o;
				remain = -1;
			end
			else
				remain--;
		end
		else
		begin
			ram_wait_i = 1'b1;
			remain = -1;
		end
	end

	// Load data compared in the cycle each hit completes.
	always @(posedge CLK)
	begin
		if (dhit_o && dmemren_i)
		begin
			assert (dmemload_o == exp_dload)
			else
			begin
				err_data++;
				$display("Fail t=%0t dmemload_o dut=%h exp=%h", $time, dmemload_o, exp_dload);
			end
		end
		if (ihit_o && imemren_i)
		begin
			assert (imemload_o == exp_iload)
			else
			begin
				err_inst++;
				$display("Fail t=%0t imemload_o dut=%h exp=%h", $time, imemload_o, exp_iload);
			end
		end
	end

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles >= LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles.", LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin
		time d_done;
		time i_done;
		void'($urandom(32'h6c28));
		nRST        = 1'b0;
		dmemren_i   = 1'b0;
		dmemwen_i   = 1'b0;
		dmemaddr_i  = '0;
		dmemstore_i = '0;
		halt_i      = 1'b0;
		imemren_i   = 1'b0;
		imemaddr_i  = '0;
		ram_load_i  = '0;
		ram_wait_i  = 1'b1;
		for (int s = 0; s < DSETS; s++)
		begin
			model_valid[0][s] = 1'b0;
			model_valid[1][s] = 1'b0;
			model_dirty[0][s] = 1'b0;
			model_dirty[1][s] = 1'b0;
			model_lru[s]      = 1'b0;
		end
		// Three tags per set keep the two ways evicting.
		for (int n = 0; n < NRAND; n++)
		begin
			rnd_wr[n]   = 1'($urandom_range(1, 0));
			rnd_addr[n] = {dtag_t'($urandom_range(3, 1)), didx_t'($urandom_range(7, 0)),
				1'($urandom_range(1, 0)), 2'b00};
			rnd_data[n] = $urandom;
		end
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
		@(negedge CLK);

		data_access(1'b1, 32'h0000_0050, 32'h1111_0000, d_done);
		data_access(1'b0, 32'h0000_0050, '0, d_done);
		data_access(1'b1, 32'h0000_0054, 32'h2222_0004, d_done);
		data_access(1'b1, 32'h0000_0090, 32'h3333_0090, d_done);
		data_access(1'b0, 32'h0000_00D0, '0, d_done);   // Evicts the dirty tag 1 block.
		data_access(1'b0, 32'h0000_0050, '0, d_done);
		data_access(1'b0, 32'h0000_0054, '0, d_done);
		data_access(1'b0, 32'h0000_0094, '0, d_done);
		for (int n = 0; n < NRAND; n++)
			data_access(rnd_wr[n], rnd_addr[n], rnd_data[n], d_done);

		fetch_instr(32'h0000_2004, 1'b0, i_done);
		fetch_instr(32'h0000_2004, 1'b1, i_done);
		fetch_instr(32'h0000_2010, 1'b0, i_done);
		fetch_instr(32'h0000_2044, 1'b0, i_done);   // Same index, other tag.
		fetch_instr(32'h0000_2010, 1'b1, i_done);
		fetch_instr(32'h0000_2004, 1'b0, i_done);

		fork
			data_access(1'b0, 32'h0000_0188, '0, d_done);
			fetch_instr(32'h0000_2080, 1'b0, i_done);
		join
		assert (d_done < i_done)
		else
		begin
			err_seq++;
			$display("Instruction fetch finished before the competing data miss");
		end

		assert (wb_addr.size() == 0)
		else
		begin
			err_seq++;
			$display("%0d predicted writebacks never reached RAM", wb_addr.size());
		end
		halt_i   = 1'b1;
		flushing = 1'b1;
		@(posedge CLK);
		while (!flushed_o)
			@(posedge CLK);
		foreach (gold[a])
		begin
			assert (ram_word(a) == gold[a])
			else
			begin
				err_ram++;
				$display("Fail t=%0t ram[%h] dut=%h exp=%h", $time, a, ram_word(a), gold[a]);
			end
		end
		assert (ram_word(HIT_CNT_ADDR) == word_t'(model_cnt))
		else
		begin
			err_ram++;
			$display("Fail t=%0t hit_cnt dut=%h exp=%h", $time, ram_word(HIT_CNT_ADDR),
				word_t'(model_cnt));
		end

		$display("Errors: data %0d, fetch %0d, ram %0d, sequence %0d",
			err_data, err_inst, err_ram, err_seq);
		if (err_data + err_inst + err_ram + err_seq == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: sources.f
hw/cache_pkg.sv
hw/dcache.sv
hw/icache.sv
hw/memory_control.sv
hw/cache_subsystem.sv
test/cache_subsystem_props.sv
test/cache_subsystem_tb.sv

// File: Makefile
TOP = cache_subsystem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
